//--- sources.f
+incdir+rtl
rtl/zbus_pkg.sv
rtl/xt_regs_pkg.sv
rtl/port_decode.sv
rtl/xt_regfile.sv
rtl/periph_ports.sv
rtl/wait_fsm.sv
rtl/zx_ports.sv
sim/zx_ports_sva.sv
sim/zx_ports_tb.sv

//--- sim/zx_ports_tb.sv
// testbench for the I/O port block, directed tests with a wait-channel agent model
`default_nettype none

`include "zx_ports_defines.svh"

module zx_ports_tb;

  import zbus_pkg::*;
  import xt_regs_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int TEST_COUNT      = 5;
  localparam int CYCLES_PER_TEST = 400;
  localparam int WAIT_LIMIT      = 50;   // cycles allowed for one wait transfer

  logic       clk;
  logic       rst;
  acc_t       acc;
  logic       dos;
  logic       opfetch;
  logic [4:0] keys_in;
  logic       tape_read;
  logic [7:0] sd_dataout;
  logic       ack;
  logic [7:0] wait_read;
  logic [7:0] dout;
  logic       porthit;
  mem_cfg_t   mem_cfg;
  logic       sd_cs_n;
  logic       sd_start;
  logic [7:0] sd_datain;
  wait_req_t  wait_req;
  logic       req;
  logic       busy;

  int         checks;
  int         errors;
  int         test_checks;
  int         test_errors;
  logic [7:0] snap_dout;     // combinational outputs seen in the strobe cycle
  logic       snap_hit;
  logic       snap_start;
  logic [7:0] snap_datain;
  logic [7:0] agent_byte;    // last byte the agent returned

  zx_ports dut_i (.clk, .rst, .acc, .dos, .opfetch, .keys_in, .tape_read, .sd_dataout,
    .ack, .wait_read, .dout, .porthit, .mem_cfg, .sd_cs_n, .sd_start, .sd_datain,
    .wait_req, .req, .busy);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(CLK_PERIOD * (TEST_COUNT * CYCLES_PER_TEST + 10));
    $display("watchdog expired, the tests did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  // wait agent: ack after 1..4 cycles, release once req is gone
  initial
  begin : agent
    int delay;
    ack        = 1'b0;
    wait_read  = 8'h00;
    agent_byte = 8'h00;
    forever
    begin
      @(posedge clk);
      #2;
      if (req)
      begin
        delay = $urandom_range(4, 1);
        repeat (delay) @(posedge clk);
        #2;
        agent_byte = 8'($urandom);
        wait_read  = agent_byte;
        ack        = 1'b1;
        do
        begin
          @(posedge clk);
          #2;
        end
        while (req);
        ack = 1'b0;
      end
    end
  end

  function automatic logic [7:0] random_byte();
    return 8'($urandom);
  endfunction

  // page 3 after a #7FFD write, by lock mode
  function automatic logic [7:0] expect_page3(input logic [1:0] mode, input logic [7:0] d,
                                               input logic op_equal);
    logic [1:0] bank;
    if (mode == 2'd3)
      return {2'b00, d[5], d[7], d[6], d[2:0]};
    bank = ((mode == 2'd1) || (mode == 2'd2 && op_equal)) ? 2'b00 : d[7:6];
    return {3'b000, bank, d[2:0]};
  endfunction

  task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
  endtask

  // one strobe cycle, then strobes drop; returns at +2 after the following edge
  task automatic bus_access(input logic [15:0] addr, input logic [7:0] data,
                            input logic write);
    @(posedge clk);
    #2;
    acc.address = addr;
    acc.data    = data;
    acc.rd      = !write;
    acc.wr      = write;
    #8;
    snap_dout   = dout;
    snap_hit    = porthit;
    snap_start  = sd_start;
    snap_datain = sd_datain;
    @(posedge clk);
    #2;
    acc.rd = 1'b0;
    acc.wr = 1'b0;
  endtask

  task automatic fetch_opcode(input logic [7:0] op);
    @(posedge clk);
    #2;
    acc.data = op;
    opfetch  = 1'b1;
    @(posedge clk);
    #2;
    opfetch = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (busy && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    checks++;
    assert (!busy)
    else
    begin
      $display("wait transfer never finished, busy is still high");
      errors++;
    end
  endtask

  task automatic reset_defaults();
    logic [3:0][7:0] pages;
    logic [7:0]      r;
    start_test();
    pages = {`ZXP_RST_RAMPAGE3, `ZXP_RST_RAMPAGE2, `ZXP_RST_RAMPAGE1, `ZXP_RST_RAMPAGE0};
    for (int i = 0; i < 4; i++)
      check_val("mem_cfg.rampage", mem_cfg.rampage[i], pages[i]);
    check_val("mem_cfg.memconf", mem_cfg.memconf, `ZXP_RST_MEMCONF);
    check_val("mem_cfg.intmask", mem_cfg.intmask, `ZXP_RST_INTMASK);
    check_val("sd_cs_n", sd_cs_n, 8'h01);
    check_val("sd_start", sd_start, 8'h00);
    check_val("req", req, 8'h00);
    check_val("busy", busy, 8'h00);
    for (int i = 0; i < 4; i++)
    begin
      bus_access({`ZXP_REG_RAMPAGE + 8'(i), `ZXP_PORT_XT}, 8'h00, 1'b0);
      check_val("dout", snap_dout, pages[i]);
      check_val("porthit", snap_hit, 8'h01);
    end
    r = random_byte();
    keys_in   = r[4:0];
    tape_read = r[7];
    bus_access({8'hFE, `ZXP_PORT_FE}, 8'h00, 1'b0);
    check_val("dout", snap_dout, {1'b1, r[7], 1'b0, r[4:0]});
    check_val("porthit", snap_hit, 8'h01);
    finish_test("reset_defaults");
  endtask

  task automatic xt_registers();
    logic [7:0] d;
    logic [7:0] c;
    start_test();
    for (int i = 0; i < 4; i++)
    begin
      d = random_byte();
      bus_access({`ZXP_REG_RAMPAGE + 8'(i), `ZXP_PORT_XT}, d, 1'b1);
      check_val("mem_cfg.rampage", mem_cfg.rampage[i], d);
      bus_access({`ZXP_REG_RAMPAGE + 8'(i), `ZXP_PORT_XT}, 8'h00, 1'b0);
      check_val("dout", snap_dout, d);
    end
    d = random_byte();
    bus_access({`ZXP_REG_INTMASK, `ZXP_PORT_XT}, d, 1'b1);
    check_val("mem_cfg.intmask", mem_cfg.intmask, d);
    d = random_byte();
    bus_access({`ZXP_REG_MEMCONF, `ZXP_PORT_XT}, d, 1'b1);
    check_val("mem_cfg.memconf", mem_cfg.memconf, d);
    d = random_byte() | 8'h04;   // cache bit set, differs from reset
    bus_access({`ZXP_REG_SYSCONF, `ZXP_PORT_XT}, d, 1'b1);
    check_val("mem_cfg.sysconf", mem_cfg.sysconf, d);
    check_val("mem_cfg.cacheconf", mem_cfg.cacheconf, {4'h0, {4{d[2]}}});
    c = random_byte() & 8'hF7;
    bus_access({`ZXP_REG_CACHECONF, `ZXP_PORT_XT}, c, 1'b1);
    check_val("mem_cfg.cacheconf", mem_cfg.cacheconf, {4'h0, c[3:0]});
    check_val("mem_cfg.sysconf", mem_cfg.sysconf, d);
    // only the pages are readable
    bus_access({`ZXP_REG_SYSCONF, `ZXP_PORT_XT}, 8'h00, 1'b0);
    check_val("dout", snap_dout, 8'hFF);
    bus_access({8'h55, `ZXP_PORT_XT}, 8'h00, 1'b0);
    check_val("dout", snap_dout, 8'hFF);
    finish_test("xt_registers");
  endtask

  task automatic paging_step(input logic [1:0] mode, input logic [7:0] op, input logic [7:0] d);
    bus_access({`ZXP_REG_MEMCONF, `ZXP_PORT_XT}, {mode, 6'b000100}, 1'b1);
    fetch_opcode(op);
    bus_access({8'h7F, `ZXP_PORT_FD}, d, 1'b1);
    check_val("mem_cfg.rampage[3]", mem_cfg.rampage[3], expect_page3(mode, d, op[7] == op[6]));
    check_val("mem_cfg.memconf[0]", mem_cfg.memconf[0], d[4]);
  endtask

  task automatic paging();
    logic [7:0] d;
    logic [7:0] page3;
    logic       rom;
    start_test();
    paging_step(2'd3, 8'h00, (random_byte() & 8'h7F) | 8'h60);   // bit 5 is a bank bit here
    paging_step(2'd2, 8'hC9, (random_byte() & 8'hDF) | 8'hC0);
    paging_step(2'd2, 8'h8F, (random_byte() & 8'hDF) | 8'hC0);
    paging_step(2'd1, 8'h40, (random_byte() & 8'hDF) | 8'hC0);
    d = (random_byte() & 8'hDF) | 8'hC0;
    paging_step(2'd0, 8'h40, d);
    page3 = mem_cfg.rampage[3];
    rom   = mem_cfg.memconf[0];
    bus_access(16'hFFFD, ~d & 8'hDF, 1'b1);   // AY port, not paging
    check_val("porthit", snap_hit, 8'h00);
    check_val("mem_cfg.rampage[3]", mem_cfg.rampage[3], page3);
    check_val("mem_cfg.memconf[0]", mem_cfg.memconf[0], rom);
    d = random_byte() | 8'h20;
    bus_access(16'h7FFD, d, 1'b1);
    check_val("mem_cfg.rampage[3]", mem_cfg.rampage[3], expect_page3(2'd0, d, 1'b0));
    check_val("mem_cfg.memconf[0]", mem_cfg.memconf[0], d[4]);
    page3 = mem_cfg.rampage[3];
    rom   = mem_cfg.memconf[0];
    bus_access(16'h7FFD, ~d, 1'b1);
    check_val("mem_cfg.rampage[3]", mem_cfg.rampage[3], page3);
    check_val("mem_cfg.memconf[0]", mem_cfg.memconf[0], rom);
    finish_test("paging");
  endtask

  task automatic sd_port();
    logic [7:0] d;
    start_test();
    dos = 1'b0;
    d = random_byte();
    bus_access({8'h00, `ZXP_PORT_SDCFG}, d, 1'b1);
    check_val("sd_cs_n", sd_cs_n, !d[2]);
    d = ~d;
    bus_access({8'h00, `ZXP_PORT_SDCFG}, d, 1'b1);
    check_val("sd_cs_n", sd_cs_n, !d[2]);
    dos = 1'b1;   // port hidden, cs keeps its value
    bus_access({8'h00, `ZXP_PORT_SDCFG}, ~d, 1'b1);
    check_val("porthit", snap_hit, 8'h00);
    check_val("sd_cs_n", sd_cs_n, !d[2]);
    dos = 1'b0;
    d = random_byte();
    bus_access({8'h00, `ZXP_PORT_SDDAT}, d, 1'b1);
    check_val("porthit", snap_hit, 8'h01);
    check_val("sd_start", snap_start, 8'h01);
    check_val("sd_datain", snap_datain, d);
    #8;   // strobe gone, decode settled
    check_val("sd_start", sd_start, 8'h00);
    sd_dataout = random_byte();
    bus_access({8'h00, `ZXP_PORT_SDDAT}, 8'h00, 1'b0);
    check_val("sd_start", snap_start, 8'h01);
    check_val("sd_datain", snap_datain, 8'hFF);
    check_val("dout", snap_dout, sd_dataout);
    finish_test("sd_port");
  endtask

  task automatic wait_ports();
    logic [7:0] h;
    logic [7:0] a;
    logic [7:0] d;
    logic [7:0] got;
    start_test();
    dos = 1'b0;
    h = 8'hF8 | random_byte();
    bus_access({h, `ZXP_PORT_COM}, 8'h00, 1'b0);
    check_val("porthit", snap_hit, 8'h01);
    check_val("req", req, 8'h01);
    check_val("wait_req.addr", wait_req.addr, h);
    check_val("wait_req.com", wait_req.com, 8'h01);
    check_val("wait_req.write", wait_req.write, 8'h00);
    wait_done();
    got = agent_byte;
    bus_access({h, `ZXP_PORT_COM}, 8'h00, 1'b0);
    check_val("dout", snap_dout, got);
    wait_done();
    bus_access(16'hEFF7, 8'h80, 1'b1);   // gluclock on
    a = random_byte();
    bus_access(16'hDFF7, a, 1'b1);
    d = random_byte();
    bus_access(16'hBFF7, d, 1'b1);
    check_val("req", req, 8'h01);
    check_val("wait_req.addr", wait_req.addr, a);
    check_val("wait_req.data", wait_req.data, d);
    check_val("wait_req.write", wait_req.write, 8'h01);
    check_val("wait_req.com", wait_req.com, 8'h00);
    wait_done();
    bus_access(16'hEFF7, 8'h00, 1'b1);
    bus_access(16'hBFF7, random_byte(), 1'b1);
    check_val("req", req, 8'h00);
    check_val("busy", busy, 8'h00);
    finish_test("wait_ports");
  endtask

  initial
  begin
    int sva_fails;
    void'($urandom(32'hfc77));
    rst        = 1'b1;
    acc        = '0;
    dos        = 1'b0;
    opfetch    = 1'b0;
    keys_in    = 5'h00;
    tape_read  = 1'b0;
    sd_dataout = 8'h00;
    checks     = 0;
    errors     = 0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_defaults();
    xt_registers();
    paging();
    sd_port();
    wait_ports();
    sva_fails = dut_i.wait_i.sva_i.fail_count;
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/zx_ports_sva.sv
// wait-channel handshake assertions, bound into the wait FSM
`default_nettype none

module zx_ports_sva (
  input logic                clk,
  input logic                rst,
  input logic                req,
  input logic                ack,
  input logic                busy,
  input zbus_pkg::wait_req_t wait_req
);

  int fail_count = 0;   // failed assertions so far

  // a new request only after the agent released ack
  req_after_ack_low: assert property (@(posedge clk) disable iff (rst) $rose(req) |-> !ack)
  else
  begin
    $error("req rose while ack was high");
    fail_count++;
  end

  req_data_stable: assert property (@(posedge clk) disable iff (rst)
    (req && $past(req)) |-> $stable(wait_req))
  else
  begin
    $error("wait_req changed while req was high");
    fail_count++;
  end

  // busy spans the whole handshake, ack phase included
  busy_covers_req: assert property (@(posedge clk) disable iff (rst) (req || ack) |-> busy)
  else
  begin
    $error("req or ack high without busy");
    fail_count++;
  end

endmodule

bind wait_fsm zx_ports_sva sva_i (.clk, .rst, .req, .ack, .busy, .wait_req);

`default_nettype wire

//--- rtl/zx_ports.sv
// I/O port block top, connects decoder, register file, peripherals and wait FSM
`default_nettype none

module zx_ports (
  input  logic                  clk,
  input  logic                  rst,
  input  zbus_pkg::acc_t        acc,
  input  logic                  dos,
  input  logic                  opfetch,
  input  logic [4:0]            keys_in,
  input  logic                  tape_read,
  input  logic [7:0]            sd_dataout,
  input  logic                  ack,
  input  logic [7:0]            wait_read,
  output logic [7:0]            dout,
  output logic                  porthit,
  output xt_regs_pkg::mem_cfg_t mem_cfg,
  output logic                  sd_cs_n,
  output logic                  sd_start,
  output logic [7:0]            sd_datain,
  output zbus_pkg::wait_req_t   wait_req,
  output logic                  req,
  output logic                  busy
);

  import xt_regs_pkg::*;

  port_hit_t  hit;
  logic       lock48;
  logic       xt_wr, p7ffd_wr, sdcfg_wr, sdsta;
  logic       f7_wr, f7_rd, com_wr, com_rd;
  logic       gluclock_on;
  logic [7:0] wait_data;   // last byte read from the agent

  port_decode decode_i (.acc, .dos, .lock48, .hit, .porthit, .xt_wr, .p7ffd_wr,
    .sdcfg_wr, .sdsta, .f7_wr, .f7_rd, .com_wr, .com_rd);

  xt_regfile regfile_i (.clk, .rst, .acc, .hit, .xt_wr, .p7ffd_wr, .opfetch,
    .mem_cfg, .lock48);

  periph_ports periph_i (.clk, .rst, .acc, .hit, .sdcfg_wr, .sdsta, .f7_wr, .dos,
    .keys_in, .tape_read, .sd_dataout, .mem_cfg, .wait_data, .sd_cs_n, .sd_start,
    .sd_datain, .gluclock_on, .dout);

  wait_fsm wait_i (.clk, .rst, .acc, .hit, .f7_wr, .f7_rd, .com_wr, .com_rd, .xt_wr,
    .gluclock_on, .wait_req, .req, .busy, .ack, .wait_read, .wait_data);

endmodule

`default_nettype wire

//--- rtl/wait_fsm.sv
// wait-port FSM, runs gluclock and serial transfers over a four-phase req/ack
`default_nettype none

`include "zx_ports_defines.svh"

module wait_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  zbus_pkg::acc_t         acc,
  input  xt_regs_pkg::port_hit_t hit,
  input  logic                   f7_wr,
  input  logic                   f7_rd,
  input  logic                   com_wr,
  input  logic                   com_rd,
  input  logic                   xt_wr,
  input  logic                   gluclock_on,
  output zbus_pkg::wait_req_t    wait_req,
  output logic                   req,
  output logic                   busy,
  input  logic                   ack,
  input  logic [7:0]             wait_read,
  output logic [7:0]             wait_data
);

  import zbus_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_REQUEST, ST_ACK_LOW, ST_DONE} state_t;

  state_t     state;
  logic [7:0] glu_addr;
  logic       glu_start;
  logic       com_start;
  logic       start;
  wait_req_t  next_req;

  assign glu_start = gluclock_on && !acc.address[14] && (f7_wr || f7_rd);  // #BFF7
  assign com_start = com_wr || com_rd;
  // strobes while busy are dropped
  assign start = (glu_start || com_start) && (state == ST_IDLE || state == ST_DONE);

  always_comb
  begin
    next_req.addr  = com_start ? hit.hoa : glu_addr;
    next_req.data  = acc.data;
    next_req.write = f7_wr || com_wr;
    next_req.com   = com_start;
  end

  // gluclock register number, via #DFF7 or the dma wait-address register
  always_ff @(posedge clk)
  begin
    if (gluclock_on && f7_wr && !acc.address[13])
      glu_addr <= acc.data;
    else if (xt_wr && (hit.hoa == `ZXP_REG_WAITADR))
      glu_addr <= acc.data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ST_IDLE;
    else
      case (state)
        ST_IDLE, ST_DONE: state <= start ? ST_REQUEST : ST_IDLE;
        ST_REQUEST:       if (ack) state <= ST_ACK_LOW;
        ST_ACK_LOW:       if (!ack) state <= ST_DONE;   // agent released, done next
        default:          state <= ST_IDLE;
      endcase
  end

  always_ff @(posedge clk)
  begin
    if (start)
      wait_req <= next_req;   // held until the next start
    if (state == ST_REQUEST && ack && !wait_req.write)
      wait_data <= wait_read;
  end

  assign req  = (state == ST_REQUEST);
  assign busy = (state == ST_REQUEST) || (state == ST_ACK_LOW);

endmodule

`default_nettype wire

//--- rtl/periph_ports.sv
// keyboard/tape, Z-controller SD and #EFF7 ports, plus the port read multiplexer
`default_nettype none

`include "zx_ports_defines.svh"

module periph_ports (
  input  logic                   clk,
  input  logic                   rst,
  input  zbus_pkg::acc_t         acc,
  input  xt_regs_pkg::port_hit_t hit,
  input  logic                   sdcfg_wr,
  input  logic                   sdsta,
  input  logic                   f7_wr,
  input  logic                   dos,
  input  logic [4:0]             keys_in,
  input  logic                   tape_read,
  input  logic [7:0]             sd_dataout,
  input  xt_regs_pkg::mem_cfg_t  mem_cfg,
  input  logic [7:0]             wait_data,
  output logic                   sd_cs_n,
  output logic                   sd_start,
  output logic [7:0]             sd_datain,
  output logic                   gluclock_on,
  output logic [7:0]             dout
);

  logic glu_en;   // #EFF7 bit 7, the only bit kept

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sd_cs_n <= 1'b1;
      glu_en  <= 1'b0;
    end
    else
    begin
      if (sdcfg_wr)
        sd_cs_n <= ~acc.data[2];
      if (f7_wr && !acc.address[12])   // #EFF7
        glu_en <= acc.data[7];
    end
  end

  // gluclock stays reachable in dos
  assign gluclock_on = glu_en || dos;

  assign sd_start  = sdsta;
  assign sd_datain = acc.wr ? acc.data : 8'hFF;   // reads clock out FF

  always_comb
  begin
    dout = 8'hFF;
    if (hit.fe)
      dout = {1'b1, tape_read, 1'b0, keys_in};
    else if (hit.xt)
    begin
      if ((hit.hoa & 8'hFC) == `ZXP_REG_RAMPAGE)
        dout = mem_cfg.rampage[hit.hoa[1:0]];
    end
    else if (hit.sdcfg)
      dout = 8'h00;   // card present, not write protected
    else if (hit.sddat)
      dout = sd_dataout;
    else if (hit.f7)
    begin
      if (!acc.address[14] && gluclock_on)   // #BFF7 data
        dout = wait_data;
    end
    else if (hit.com)
      dout = wait_data;
  end

endmodule

`default_nettype wire

//--- rtl/xt_regfile.sv
// extended #nnAF register file plus #7FFD paging with lock-128/lock-48 modes
`default_nettype none

`include "zx_ports_defines.svh"

module xt_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  zbus_pkg::acc_t         acc,
  input  xt_regs_pkg::port_hit_t hit,
  input  logic                   xt_wr,
  input  logic                   p7ffd_wr,
  input  logic                   opfetch,
  output xt_regs_pkg::mem_cfg_t  mem_cfg,
  output logic                   lock48
);

  logic [7:0] d;
  logic [1:0] lock_mode;   // memconf[7:6]
  logic       m1_lock;     // last opcode had bits 7 and 6 equal
  logic       lock128;
  logic [7:0] page3_next;

  assign d         = acc.data;
  assign lock_mode = mem_cfg.memconf[7:6];

  // mode 1 always locks, mode 2 locks by the fetched opcode
  assign lock128 = (lock_mode == 2'd2) ? m1_lock : (lock_mode == 2'd1);

  always_ff @(posedge clk)
  begin
    if (rst)
      m1_lock <= 1'b0;
    else if (opfetch)
      m1_lock <= (d[7] == d[6]);
  end

  always_comb
  begin
    if (lock_mode == 2'd3)
      page3_next = {2'b00, d[5], d[7:6], d[2:0]};   // 1M paging, bit 5 is a bank bit
    else
      page3_next = {3'b000, lock128 ? 2'b00 : d[7:6], d[2:0]};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_cfg.rampage[0] <= `ZXP_RST_RAMPAGE0;
      mem_cfg.rampage[1] <= `ZXP_RST_RAMPAGE1;
      mem_cfg.rampage[2] <= `ZXP_RST_RAMPAGE2;
      mem_cfg.rampage[3] <= `ZXP_RST_RAMPAGE3;
      mem_cfg.memconf    <= `ZXP_RST_MEMCONF;
      mem_cfg.sysconf    <= 8'h00;              // 3.5 MHz
      mem_cfg.cacheconf  <= 4'h0;
      mem_cfg.intmask    <= `ZXP_RST_INTMASK;
      lock48             <= 1'b0;
    end
    else if (p7ffd_wr)
    begin
      mem_cfg.memconf[0] <= d[4];   // rom select
      mem_cfg.rampage[3] <= page3_next;
      if (lock_mode != 2'd3)
        lock48 <= d[5];
    end
    else if (xt_wr)
    begin
      if ((hit.hoa & 8'hFC) == `ZXP_REG_RAMPAGE)
        mem_cfg.rampage[hit.hoa[1:0]] <= d;

      case (hit.hoa)
        `ZXP_REG_SYSCONF:
        begin
          mem_cfg.sysconf   <= d;
          mem_cfg.cacheconf <= {4{d[2]}};   // cache follows sysconf by default
        end
        `ZXP_REG_MEMCONF:   mem_cfg.memconf   <= d;
        `ZXP_REG_CACHECONF: mem_cfg.cacheconf <= d[3:0];
        `ZXP_REG_INTMASK:   mem_cfg.intmask   <= d;
        default:            ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/port_decode.sv
// port address decoder, gives hit flags and qualified read/write strobes
`default_nettype none

`include "zx_ports_defines.svh"

module port_decode (
  input  zbus_pkg::acc_t       acc,
  input  logic                 dos,
  input  logic                 lock48,
  output xt_regs_pkg::port_hit_t hit,
  output logic                 porthit,
  output logic                 xt_wr,
  output logic                 p7ffd_wr,
  output logic                 sdcfg_wr,
  output logic                 sdsta,
  output logic                 f7_wr,
  output logic                 f7_rd,
  output logic                 com_wr,
  output logic                 com_rd
);

  logic [7:0] loa;
  logic       rdwr;

  assign loa  = acc.address[7:0];
  assign rdwr = acc.rd || acc.wr;

  always_comb
  begin
    hit.fe    = (loa == `ZXP_PORT_FE);
    hit.xt    = (loa == `ZXP_PORT_XT);
    hit.p7ffd = (loa == `ZXP_PORT_FD) && !acc.address[15];  // #FFFD is not paging
    hit.sdcfg = (loa == `ZXP_PORT_SDCFG);
    hit.sddat = (loa == `ZXP_PORT_SDDAT);
    hit.f7    = (loa == `ZXP_PORT_F7) && acc.address[8];
    hit.com   = (loa == `ZXP_PORT_COM);
    hit.hoa   = acc.address[15:8];
  end

  // SD and F7 ports are hidden while dos is active
  assign porthit = hit.fe || hit.xt || hit.p7ffd || hit.com
                || (!dos && (hit.sdcfg || hit.sddat || hit.f7));

  assign xt_wr    = hit.xt && acc.wr;
  assign p7ffd_wr = hit.p7ffd && acc.wr && !lock48;   // frozen in 48k mode
  assign sdcfg_wr = hit.sdcfg && acc.wr && !dos;
  assign sdsta    = hit.sddat && rdwr && !dos;         // any #57 access starts spi

  assign f7_wr  = hit.f7 && acc.wr && !dos;
  assign f7_rd  = hit.f7 && acc.rd && !dos;
  assign com_wr = hit.com && acc.wr;
  assign com_rd = hit.com && acc.rd;

endmodule

`default_nettype wire

//--- rtl/xt_regs_pkg.sv
// register-side types: memory configuration state and decoded port hits
`default_nettype none

package xt_regs_pkg;

  typedef struct packed {
    logic [3:0][7:0] rampage;   // pages #10..#13
    logic [7:0]      memconf;
    logic [7:0]      sysconf;
    logic [3:0]      cacheconf;
    logic [7:0]      intmask;
  } mem_cfg_t;

  // address match flags, dos and lock rules not applied here
  typedef struct packed {
    logic       fe;
    logic       xt;
    logic       p7ffd;
    logic       sdcfg;
    logic       sddat;
    logic       f7;         // xxF7 with a8 high
    logic       com;
    logic [7:0] hoa;        // high address byte
  } port_hit_t;

endpackage

`default_nettype wire

//--- rtl/zbus_pkg.sv
// bus-side types: one port access and one wait-channel transfer
`default_nettype none

package zbus_pkg;

  // single bus access, strobes last one cycle
  typedef struct packed {
    logic [15:0] address;
    logic [7:0]  data;    // write data
    logic        rd;
    logic        wr;
  } acc_t;

  // request presented to the wait agent
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
    logic       write;
    logic       com;      // serial port, else gluclock
  } wait_req_t;

endpackage

`default_nettype wire

//--- rtl/zx_ports_defines.svh
// port block constants: port addresses, #nnAF register numbers, reset values
`ifndef ZX_PORTS_DEFINES_SVH
`define ZX_PORTS_DEFINES_SVH

// low byte of the port address
`define ZXP_PORT_FE     8'hFE
`define ZXP_PORT_FD     8'hFD
`define ZXP_PORT_XT     8'hAF
`define ZXP_PORT_F7     8'hF7
// serial ports live at #F8EF..#FFEF
`define ZXP_PORT_COM    8'hEF
`define ZXP_PORT_SDCFG  8'h77
`define ZXP_PORT_SDDAT  8'h57

// high byte of #nnAF, the register number
`define ZXP_REG_RAMPAGE   8'h10
`define ZXP_REG_SYSCONF   8'h20
`define ZXP_REG_MEMCONF   8'h21
`define ZXP_REG_INTMASK   8'h2A
`define ZXP_REG_CACHECONF 8'h2B
// dma wait-address register
`define ZXP_REG_WAITADR   8'h2D

// values after reset
`define ZXP_RST_MEMCONF   8'h04
`define ZXP_RST_RAMPAGE0  8'h00
`define ZXP_RST_RAMPAGE1  8'h05
`define ZXP_RST_RAMPAGE2  8'h02
`define ZXP_RST_RAMPAGE3  8'h00
`define ZXP_RST_INTMASK   8'h01

`endif
